// ==== list.f ====
+incdir+design
design/shift_pkg.sv
design/barrel_shifter.sv
design/operand_resolver.sv
design/shift_stage.sv
testbench/shift_monitor.sv
testbench/shift_stage_chk.sv
testbench/tb_shift_stage.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_shift_stage
FILELIST = list.f

BIN      = obj_dir/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
RUN_ARGS = +verilator+error+limit+1000
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '** FAIL **' $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/tb_shift_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shift_config.svh"

module tb_shift_stage
        import shift_pkg::*;
();

localparam int    RESET_CYCLES = 16;
localparam cond_t COND_NV      = cond_t'(`SHIFT_COND_NV);
localparam word_t SRC_A        = 32'h8000_0003;

// One row of the stimulus table with the value expected one cycle later.
typedef struct packed
{
        issue_bundle_t issue;
        alu_fwd_t      fwd;
        logic          wb_clr;
        logic          stall;
        logic          alu_clr;
        logic          carry_ff;
        logic          carry_nxt;
        stage_out_t    exp_out;
} entry_t;

logic          i_clk;
logic          i_reset;
logic          i_clear_from_writeback;
logic          i_data_stall;
logic          i_clear_from_alu;
logic          i_cpsr_carry_ff;
logic          i_cpsr_carry_nxt;
issue_bundle_t i_issue;
alu_fwd_t      i_alu_fwd;
stage_out_t    o_stage;

// Expected value and enable handed to the monitor.
stage_out_t    exp_drv;
logic          check_drv;
int            mon_errors;

entry_t        stim_q[$];
int            cycle_count = 0;
int            cycle_limit = 0;
int            total_errors;

shift_stage shift_stage_inst
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_cpsr_carry_ff        (i_cpsr_carry_ff),
        .i_cpsr_carry_nxt       (i_cpsr_carry_nxt),
        .i_issue                (i_issue),
        .i_alu_fwd              (i_alu_fwd),
        .o_stage                (o_stage)
);

shift_monitor u_monitor
(
        .i_clk    (i_clk),
        .i_stage  (o_stage),
        .i_expect (exp_drv),
        .i_check  (check_drv),
        .o_errors (mon_errors)
);

// Protocol checks ride along inside the DUT.
bind shift_stage shift_stage_chk u_chk
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stage                (o_stage)
);

always #5 i_clk = ~i_clk;

// Run limit from table length.
always @(posedge i_clk)
begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
        begin
                $display("Timeout: run did not finish within %0d cycles", cycle_limit);
                $display("** FAIL **");
                $finish;
        end
end

//////////////////////////////////////////////////////////////////////
// Table helpers.
//////////////////////////////////////////////////////////////////////

function automatic src_sel_t imm_src(input word_t value);
        src_sel_t s;

        s.imm     = 1'b1;
        s.payload = value;
        return s;
endfunction

function automatic src_sel_t reg_src(input reg_index_t idx);
        src_sel_t s;

        s.imm     = 1'b0;
        s.payload = 32'(idx);
        return s;
endfunction

// Plain AL instruction, alu source immediate, rm is r2, store data r3.
function automatic issue_bundle_t base_issue();
        issue_bundle_t b;

        b                   = '0;
        b.cond              = 4'hE;
        b.dest_index        = 6'd1;
        b.alu_op            = 5'd4;
        b.shift_type        = SH_LSL;
        b.flag_update       = 1'b1;
        b.alu_src           = imm_src(32'h0000_0011);
        b.shift_src         = reg_src(6'd2);
        b.mem_srcdest_index = 6'd3;
        b.alu_src_value     = 32'hA0A0_0001;
        b.mem_srcdest_value = 32'h5555_0003;
        b.pc_plus_8         = 32'h0000_1008;
        return b;
endfunction

// What the base bundle turns into when nothing forwards.
function automatic stage_out_t base_expect();
        stage_out_t e;

        e                   = '0;
        e.cond              = 4'hE;
        e.dest_index        = 6'd1;
        e.alu_op            = 5'd4;
        e.flag_update       = 1'b1;
        e.mem_srcdest_index = 6'd3;
        e.pc_plus_8         = 32'h0000_1008;
        e.alu_src_value     = 32'h0000_0011;
        e.mem_srcdest_value = 32'h5555_0003;
        return e;
endfunction

task automatic add_entry(input issue_bundle_t b, input alu_fwd_t f, input logic wb_clr,
                         input logic stall, input logic alu_clr, input logic c_ff,
                         input logic c_nxt, input stage_out_t e);
        entry_t ent;

        ent.issue     = b;
        ent.fwd       = f;
        ent.wb_clr    = wb_clr;
        ent.stall     = stall;
        ent.alu_clr   = alu_clr;
        ent.carry_ff  = c_ff;
        ent.carry_nxt = c_nxt;
        ent.exp_out   = e;
        stim_q.push_back(ent);
endtask

// Shifter row. Next carry is the inverse, it must not leak through.
task automatic add_shift(input shift_type_e t, input word_t src, input word_t len,
                         input logic cin, input word_t val, input logic cout);
        issue_bundle_t b;
        stage_out_t    e;

        b                 = base_issue();
        b.shift_type      = t;
        b.shift_src_value = src;
        b.shift_len_value = len;
        e                 = base_expect();
        e.shifted_value   = val;
        e.shift_carry     = cout;
        add_entry(b, '0, 1'b0, 1'b0, 1'b0, cin, ~cin, e);
endtask

task automatic build_table();
        issue_bundle_t b;
        issue_bundle_t b_new;
        stage_out_t    e;
        stage_out_t    e_hold;
        alu_fwd_t      fwd_on;
        alu_fwd_t      fwd_off;

        fwd_on.valid  = 1'b1;
        fwd_on.value  = 32'hF0F0_F0F0;
        fwd_off.valid = 1'b0;
        fwd_off.value = 32'hF0F0_F0F0;

        // Stall right after reset keeps the reset image.
        b      = base_issue();
        e      = '0;
        e.cond = COND_NV;
        add_entry(b, '0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, e);

        // LSL. Upper bits of the length register are ignored.
        add_shift(SH_LSL, SRC_A, 32'd0,          1'b1, SRC_A,         1'b1);
        add_shift(SH_LSL, SRC_A, 32'h0000_0301,  1'b0, 32'h0000_0006, 1'b1);
        add_shift(SH_LSL, SRC_A, 32'd31,         1'b0, 32'h8000_0000, 1'b1);
        add_shift(SH_LSL, SRC_A, 32'd32,         1'b0, 32'h0000_0000, 1'b1);
        add_shift(SH_LSL, SRC_A, 32'd40,         1'b1, 32'h0000_0000, 1'b0);
        // LSR.
        add_shift(SH_LSR, SRC_A, 32'd0,          1'b0, SRC_A,         1'b0);
        add_shift(SH_LSR, SRC_A, 32'd1,          1'b0, 32'h4000_0001, 1'b1);
        add_shift(SH_LSR, SRC_A, 32'd31,         1'b1, 32'h0000_0001, 1'b0);
        add_shift(SH_LSR, SRC_A, 32'd32,         1'b0, 32'h0000_0000, 1'b1);
        add_shift(SH_LSR, SRC_A, 32'd40,         1'b1, 32'h0000_0000, 1'b0);
        // ASR, negative and positive sources.
        add_shift(SH_ASR, SRC_A, 32'd0,          1'b0, SRC_A,         1'b0);
        add_shift(SH_ASR, SRC_A, 32'd1,          1'b0, 32'hC000_0001, 1'b1);
        add_shift(SH_ASR, SRC_A, 32'd31,         1'b1, 32'hFFFF_FFFF, 1'b0);
        add_shift(SH_ASR, SRC_A, 32'd32,         1'b0, 32'hFFFF_FFFF, 1'b1);
        add_shift(SH_ASR, SRC_A, 32'd40,         1'b0, 32'hFFFF_FFFF, 1'b1);
        add_shift(SH_ASR, 32'h4000_0000, 32'd40, 1'b1, 32'h0000_0000, 1'b0);
        // ROR. 32 is a whole turn, 40 rotates by 8.
        add_shift(SH_ROR, SRC_A, 32'd0,          1'b0, SRC_A,         1'b0);
        add_shift(SH_ROR, SRC_A, 32'd1,          1'b0, 32'hC000_0001, 1'b1);
        add_shift(SH_ROR, SRC_A, 32'd31,         1'b1, 32'h0000_0007, 1'b0);
        add_shift(SH_ROR, SRC_A, 32'd32,         1'b0, SRC_A,         1'b1);
        add_shift(SH_ROR, SRC_A, 32'd40,         1'b1, 32'h0380_0000, 1'b0);
        // RRX, amount ignored.
        add_shift(SH_RRX, SRC_A, 32'd0,          1'b1, 32'hC000_0001, 1'b1);
        add_shift(SH_RRX, SRC_A, 32'd40,         1'b0, 32'h4000_0001, 1'b1);

        // Bypass with an immediate rm. Carry is the next carry.
        b                 = base_issue();
        b.disable_shifter = 1'b1;
        b.shift_src       = imm_src(32'h0000_0ABC);
        b.shift_src_value = 32'h2222_0002;
        e                 = base_expect();
        e.shifted_value   = 32'h0000_0ABC;
        e.shift_carry     = 1'b1;
        add_entry(b, fwd_on, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, e);

        // All three operands name the PC.
        b.shift_src         = reg_src(6'd15);
        b.alu_src           = reg_src(6'd15);
        b.mem_srcdest_index = 6'd15;
        e.mem_srcdest_index = 6'd15;
        e.alu_src_value     = 32'h0000_1008;
        e.shifted_value     = 32'h0000_1008;
        e.mem_srcdest_value = 32'h0000_1008;
        e.shift_carry       = 1'b0;
        add_entry(b, fwd_on, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, e);

        // All three match the held destination r1 with valid forwarding.
        b.alu_src           = reg_src(6'd1);
        b.shift_src         = reg_src(6'd1);
        b.mem_srcdest_index = 6'd1;
        e.mem_srcdest_index = 6'd1;
        e.alu_src_value     = 32'hF0F0_F0F0;
        e.shifted_value     = 32'hF0F0_F0F0;
        e.mem_srcdest_value = 32'hF0F0_F0F0;
        e.shift_carry       = 1'b1;
        add_entry(b, fwd_on, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, e);

        // Same match, forwarding not valid.
        e.alu_src_value     = 32'hA0A0_0001;
        e.shifted_value     = 32'h2222_0002;
        e.mem_srcdest_value = 32'h5555_0003;
        e.shift_carry       = 1'b0;
        add_entry(b, fwd_off, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, e);

        // No match. This one moves the held destination to r7.
        b.dest_index        = 6'd7;
        b.alu_src           = reg_src(6'd2);
        b.shift_src         = reg_src(6'd5);
        b.mem_srcdest_index = 6'd3;
        e.dest_index        = 6'd7;
        e.mem_srcdest_index = 6'd3;
        e.shift_carry       = 1'b1;
        add_entry(b, fwd_on, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, e);

        // r7 now forwards, r1 no longer does.
        b.dest_index        = 6'd1;
        b.alu_src           = reg_src(6'd7);
        b.shift_src         = reg_src(6'd1);
        b.mem_srcdest_index = 6'd7;
        e.dest_index        = 6'd1;
        e.mem_srcdest_index = 6'd7;
        e.alu_src_value     = 32'hF0F0_F0F0;
        e.mem_srcdest_value = 32'hF0F0_F0F0;
        e.shift_carry       = 1'b0;
        add_entry(b, fwd_on, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, e);
        e_hold = e;

        // Stall with a new bundle waiting, then release.
        b                 = base_issue();
        b.cond            = 4'h0;
        b.fiq             = 1'b1;
        b.swi             = 1'b1;
        b.alu_src         = imm_src(32'h0000_0099);
        b.shift_src_value = 32'h0000_0001;
        b.shift_len_value = 32'd1;
        add_entry(b, '0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, e_hold);
        e               = base_expect();
        e.cond          = 4'h0;
        e.fiq           = 1'b1;
        e.swi           = 1'b1;
        e.alu_src_value = 32'h0000_0099;
        e.shifted_value = 32'h0000_0002;
        add_entry(b, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, e);

        // Store with exceptions pending.
        b             = base_issue();
        b.mem_store   = 1'b1;
        b.irq         = 1'b1;
        b.fiq         = 1'b1;
        b.abt         = 1'b1;
        b.swi         = 1'b1;
        b.und         = 1'b1;
        e             = base_expect();
        e.mem_store   = 1'b1;
        e.irq         = 1'b1;
        e.fiq         = 1'b1;
        e.abt         = 1'b1;
        e.swi         = 1'b1;
        e.und         = 1'b1;
        e.shift_carry = 1'b1;
        add_entry(b, '0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, e);

        // Writeback clear wins over the stall.
        b_new         = base_issue();
        b_new.alu_src = imm_src(32'h0000_0077);
        b_new.fiq     = 1'b1;
        e_hold        = e;
        e_hold.cond   = COND_NV;
        e_hold.irq    = 1'b0;
        e_hold.fiq    = 1'b0;
        e_hold.abt    = 1'b0;
        e_hold.swi    = 1'b0;
        e_hold.und    = 1'b0;
        add_entry(b_new, '0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, e_hold);

        // Reload, then ALU clear alone.
        add_entry(b, '0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, e);
        add_entry(b_new, '0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, e_hold);

        // Reload, then ALU clear under a stall holds.
        add_entry(b, '0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, e);
        add_entry(b_new, '0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, e);
endtask

task automatic apply_entry(input entry_t ent);
        i_issue                = ent.issue;
        i_alu_fwd              = ent.fwd;
        i_clear_from_writeback = ent.wb_clr;
        i_data_stall           = ent.stall;
        i_clear_from_alu       = ent.alu_clr;
        i_cpsr_carry_ff        = ent.carry_ff;
        i_cpsr_carry_nxt       = ent.carry_nxt;
        exp_drv                = ent.exp_out;
        check_drv              = 1'b1;
endtask

//////////////////////////////////////////////////////////////////////
// Main sequence.
//////////////////////////////////////////////////////////////////////

initial
begin
        i_clk                  = 1'b0;
        i_reset                = 1'b1;
        i_clear_from_writeback = 1'b0;
        i_data_stall           = 1'b0;
        i_clear_from_alu       = 1'b0;
        i_cpsr_carry_ff        = 1'b0;
        i_cpsr_carry_nxt       = 1'b0;
        i_issue                = '0;
        i_alu_fwd              = '0;
        exp_drv                = '0;
        check_drv              = 1'b0;

        build_table();
        cycle_limit = RESET_CYCLES + stim_q.size() + 20;

        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        // Each row goes in 1 ns after an edge, the monitor checks it one edge later.
        foreach (stim_q[k])
        begin
                apply_entry(stim_q[k]);
                @(posedge i_clk);
                #1;
        end

        check_drv              = 1'b0;
        i_data_stall           = 1'b0;
        i_clear_from_writeback = 1'b0;
        i_clear_from_alu       = 1'b0;
        repeat (2) @(posedge i_clk);
        #1;

        total_errors = mon_errors + shift_stage_inst.u_chk.fail_count;
        $display("Done: %0d rows, %0d compare errors, %0d assertion failures",
                 stim_q.size(), mon_errors, shift_stage_inst.u_chk.fail_count);
        if (total_errors == 0)
        begin
                $display("** PASS **");
        end
        else
        begin
                $display("** FAIL **");
        end
        $finish;
end

endmodule

`default_nettype wire

// ==== testbench/shift_stage_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shift_config.svh"

module shift_stage_chk
        import shift_pkg::*;
(
        input logic       i_clk,
        input logic       i_reset,
        input logic       i_clear_from_writeback,
        input logic       i_data_stall,
        input logic       i_clear_from_alu,
        input stage_out_t i_stage
);

// Any exception flag in the slot.
logic exc_any;

// Failed assertions so far.
int   fail_count = 0;

assign exc_any = i_stage.irq | i_stage.fiq | i_stage.abt | i_stage.swi | i_stage.und;

// A stall without a writeback clear freezes the slot.
stall_hold: assert property (@(posedge i_clk)
        (!i_reset && i_data_stall && !i_clear_from_writeback)
        |=> (i_stage == $past(i_stage)))
        else
        begin
                fail_count++;
                $error("o_stage changed during a data stall");
        end

// Either clear kills the instruction. An ALU clear loses to a stall.
clear_kills: assert property (@(posedge i_clk)
        (!i_reset && (i_clear_from_writeback || (i_clear_from_alu && !i_data_stall)))
        |=> (i_stage.cond == cond_t'(`SHIFT_COND_NV) && !exc_any))
        else
        begin
                fail_count++;
                $error("o_stage still live after a clear");
        end

// Reset leaves all control outputs inactive.
reset_idle: assert property (@(posedge i_clk)
        i_reset |=> (i_stage.cond == cond_t'(`SHIFT_COND_NV) && !exc_any
                     && !i_stage.flag_update && !i_stage.mem_store))
        else
        begin
                fail_count++;
                $error("control outputs active after reset");
        end

endmodule

`default_nettype wire

// ==== testbench/shift_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_monitor
        import shift_pkg::*;
(
        input  logic       i_clk,
        input  stage_out_t i_stage,
        input  stage_out_t i_expect,
        input  logic       i_check,
        output int         o_errors
);

// Expectation captured on the edge that loads the DUT register.
stage_out_t expect_q    = '0;
logic       check_q     = 1'b0;
int         error_count = 0;

assign o_errors = error_count;

task automatic compare_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (exp_v !== act_v)
        begin
                error_count++;
                $display("[ERROR] %0t: o_stage.%s expected 0x%08h, actual 0x%08h",
                         $time, name, exp_v, act_v);
        end
endtask

// o_stage still shows the result of the previous edge here.
always @(posedge i_clk)
begin
        if (check_q)
        begin
                compare_field("cond", 32'(expect_q.cond), 32'(i_stage.cond));
                compare_field("dest_index", 32'(expect_q.dest_index), 32'(i_stage.dest_index));
                compare_field("alu_op", 32'(expect_q.alu_op), 32'(i_stage.alu_op));
                compare_field("flag_update", 32'(expect_q.flag_update),
                              32'(i_stage.flag_update));
                compare_field("mem_srcdest_index", 32'(expect_q.mem_srcdest_index),
                              32'(i_stage.mem_srcdest_index));
                compare_field("mem_store", 32'(expect_q.mem_store), 32'(i_stage.mem_store));
                compare_field("irq", 32'(expect_q.irq), 32'(i_stage.irq));
                compare_field("fiq", 32'(expect_q.fiq), 32'(i_stage.fiq));
                compare_field("abt", 32'(expect_q.abt), 32'(i_stage.abt));
                compare_field("swi", 32'(expect_q.swi), 32'(i_stage.swi));
                compare_field("und", 32'(expect_q.und), 32'(i_stage.und));
                compare_field("pc_plus_8", expect_q.pc_plus_8, i_stage.pc_plus_8);
                compare_field("alu_src_value", expect_q.alu_src_value, i_stage.alu_src_value);
                compare_field("shifted_value", expect_q.shifted_value, i_stage.shifted_value);
                compare_field("shift_carry", 32'(expect_q.shift_carry),
                              32'(i_stage.shift_carry));
                compare_field("mem_srcdest_value", expect_q.mem_srcdest_value,
                              i_stage.mem_srcdest_value);
        end
        expect_q <= i_expect;
        check_q  <= i_check;
end

endmodule

`default_nettype wire

// ==== design/shift_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shift_config.svh"

module shift_stage
        import shift_pkg::*;
(
        input  logic          i_clk,
        input  logic          i_reset,

        // Clear and stall, highest priority first.
        input  logic          i_clear_from_writeback,
        input  logic          i_data_stall,
        input  logic          i_clear_from_alu,

        // Carry flag as registered and as about to be written.
        input  logic          i_cpsr_carry_ff,
        input  logic          i_cpsr_carry_nxt,

        input  issue_bundle_t i_issue,
        input  alu_fwd_t      i_alu_fwd,

        output stage_out_t    o_stage
);

// Resolved operands.
word_t      alu_src_res;
word_t      shift_src_res;
word_t      mem_src_res;

// Store data has only a register form.
src_sel_t   mem_src;

// Barrel shifter outputs.
word_t      shifter_out;
logic       shifter_carry;

// Selected shift result and carry.
word_t      shifted_nxt;
logic       carry_nxt;

// Value the register takes on a normal load.
stage_out_t stage_load;

//////////////////////////////////////////////////////////////////////
// Operand resolution.
//////////////////////////////////////////////////////////////////////

assign mem_src.imm     = 1'b0;
assign mem_src.payload = {{(`SHIFT_DATA_W-`SHIFT_REG_IDX_W){1'b0}},
                          i_issue.mem_srcdest_index};

// ALU source operand (rn).
operand_resolver u_res_alu
(
        .i_src         (i_issue.alu_src),
        .i_issue_value (i_issue.alu_src_value),
        .i_pc_plus_8   (i_issue.pc_plus_8),
        .i_stage_dest  (o_stage.dest_index),
        .i_alu_fwd     (i_alu_fwd),
        .o_value       (alu_src_res)
);

// Shift source operand (rm), used when the shifter is bypassed.
operand_resolver u_res_shift
(
        .i_src         (i_issue.shift_src),
        .i_issue_value (i_issue.shift_src_value),
        .i_pc_plus_8   (i_issue.pc_plus_8),
        .i_stage_dest  (o_stage.dest_index),
        .i_alu_fwd     (i_alu_fwd),
        .o_value       (shift_src_res)
);

// Store data.
operand_resolver u_res_mem
(
        .i_src         (mem_src),
        .i_issue_value (i_issue.mem_srcdest_value),
        .i_pc_plus_8   (i_issue.pc_plus_8),
        .i_stage_dest  (o_stage.dest_index),
        .i_alu_fwd     (i_alu_fwd),
        .o_value       (mem_src_res)
);

//////////////////////////////////////////////////////////////////////
// Shifter and result mux.
//////////////////////////////////////////////////////////////////////

// Shift operands come straight from issue.
barrel_shifter u_shifter
(
        .i_source     (i_issue.shift_src_value),
        .i_amount     (i_issue.shift_len_value[`SHIFT_AMT_W-1:0]),
        .i_shift_type (i_issue.shift_type),
        .i_carry      (i_cpsr_carry_ff),
        .o_result     (shifter_out),
        .o_carry      (shifter_carry)
);

// Bypassed operand keeps the upcoming carry for back to back flag use.
assign shifted_nxt = i_issue.disable_shifter ? shift_src_res : shifter_out;
assign carry_nxt   = i_issue.disable_shifter ? i_cpsr_carry_nxt : shifter_carry;

//////////////////////////////////////////////////////////////////////
// Pipeline register.
//////////////////////////////////////////////////////////////////////

// Reset image. All zero with the never condition.
function automatic stage_out_t reset_state();
        stage_out_t nxt;

        nxt      = '0;
        nxt.cond = cond_t'(`SHIFT_COND_NV);
        return nxt;
endfunction

// Kill the instruction. Data fields hold.
function automatic stage_out_t clear_state(input stage_out_t cur);
        stage_out_t nxt;

        nxt      = cur;
        nxt.cond = cond_t'(`SHIFT_COND_NV);
        nxt.irq  = 1'b0;
        nxt.fiq  = 1'b0;
        nxt.abt  = 1'b0;
        nxt.swi  = 1'b0;
        nxt.und  = 1'b0;
        return nxt;
endfunction

// New instruction.
always_comb
begin
        stage_load.cond              = i_issue.cond;
        stage_load.dest_index        = i_issue.dest_index;
        stage_load.alu_op            = i_issue.alu_op;
        stage_load.flag_update       = i_issue.flag_update;
        stage_load.mem_srcdest_index = i_issue.mem_srcdest_index;
        stage_load.mem_store         = i_issue.mem_store;
        stage_load.irq               = i_issue.irq;
        stage_load.fiq               = i_issue.fiq;
        stage_load.abt               = i_issue.abt;
        stage_load.swi               = i_issue.swi;
        stage_load.und               = i_issue.und;
        stage_load.pc_plus_8         = i_issue.pc_plus_8;
        stage_load.alu_src_value     = alu_src_res;
        stage_load.shifted_value     = shifted_nxt;
        stage_load.shift_carry       = carry_nxt;
        stage_load.mem_srcdest_value = mem_src_res;
end

// Writeback clear beats the stall, the stall beats the ALU clear.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_stage <= reset_state();
        end
        else if (i_clear_from_writeback)
        begin
                o_stage <= clear_state(o_stage);
        end
        else if (i_data_stall)
        begin
                // Hold. Issue keeps its bundle.
                o_stage <= o_stage;
        end
        else if (i_clear_from_alu)
        begin
                o_stage <= clear_state(o_stage);
        end
        else
        begin
                o_stage <= stage_load;
        end
end

endmodule

`default_nettype wire

// ==== design/operand_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "shift_config.svh"

module operand_resolver
        import shift_pkg::*;
(
        input  src_sel_t   i_src,
        input  word_t      i_issue_value,
        input  word_t      i_pc_plus_8,
        input  reg_index_t i_stage_dest,
        input  alu_fwd_t   i_alu_fwd,
        output word_t      o_value
);

// Register index carried in the low bits of the payload.
reg_index_t src_index;

assign src_index = i_src.payload[`SHIFT_REG_IDX_W-1:0];

// The value read at issue may be stale by one instruction.
// The instruction now in this stage is about to produce its result
// in the ALU, so a matching index takes the forwarded value instead.
always_comb
begin
        if (i_src.imm)
        begin
                // Immediate operand.
                o_value = i_src.payload;
        end
        else if (src_index == reg_index_t'(`SHIFT_PHY_PC))
        begin
                // PC reads as the address plus 8.
                o_value = i_pc_plus_8;
        end
        else if (src_index == i_stage_dest && i_alu_fwd.valid)
        begin
                o_value = i_alu_fwd.value;
        end
        else
        begin
                // No hazard, use what issue read.
                o_value = i_issue_value;
        end
end

endmodule

`default_nettype wire

// ==== design/barrel_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter
        import shift_pkg::*;
(
        input  word_t       i_source,
        input  shift_amt_t  i_amount,
        input  shift_type_e i_shift_type,
        input  logic        i_carry,
        output word_t       o_result,
        output logic        o_carry
);

// Amount modulo 32, enough for every in-range shift and for rotates.
logic [4:0]  amt_lo;

// Widened shift results. The extra bit catches the last bit shifted out.
logic [32:0] lsl_ext;
logic [32:0] lsr_ext;
logic [32:0] asr_ext;
logic [63:0] ror_ext;

assign amt_lo  = i_amount[4:0];
assign lsl_ext = {1'b0, i_source} << amt_lo;
assign lsr_ext = {i_source, 1'b0} >> amt_lo;
assign asr_ext = $signed({i_source, 1'b0}) >>> amt_lo;

// Doubled word shifted right gives the rotate in the low half.
assign ror_ext = {i_source, i_source} >> amt_lo;

always_comb
begin
        // Zero amount leaves value and carry untouched.
        o_result = i_source;
        o_carry  = i_carry;

        case (i_shift_type)
        SH_LSL:
        begin
                if (i_amount == '0)
                begin
                        o_result = i_source;
                end
                else if (i_amount < 8'd32)
                begin
                        o_result = lsl_ext[31:0];
                        o_carry  = lsl_ext[32];
                end
                else
                begin
                        // Exactly 32 moves bit 0 into the carry, beyond that it is lost.
                        o_result = '0;
                        o_carry  = (i_amount == 8'd32) ? i_source[0] : 1'b0;
                end
        end
        SH_LSR:
        begin
                if (i_amount == '0)
                begin
                        o_result = i_source;
                end
                else if (i_amount < 8'd32)
                begin
                        o_result = lsr_ext[32:1];
                        o_carry  = lsr_ext[0];
                end
                else
                begin
                        o_result = '0;
                        o_carry  = (i_amount == 8'd32) ? i_source[31] : 1'b0;
                end
        end
        SH_ASR:
        begin
                if (i_amount == '0)
                begin
                        o_result = i_source;
                end
                else if (i_amount < 8'd32)
                begin
                        o_result = asr_ext[32:1];
                        o_carry  = asr_ext[0];
                end
                else
                begin
                        // Saturates to the sign.
                        o_result = {32{i_source[31]}};
                        o_carry  = i_source[31];
                end
        end
        SH_ROR:
        begin
                if (i_amount == '0)
                begin
                        o_result = i_source;
                end
                else if (amt_lo == '0)
                begin
                        // Whole turns of the word.
                        o_result = i_source;
                        o_carry  = i_source[31];
                end
                else
                begin
                        o_result = ror_ext[31:0];
                        o_carry  = ror_ext[31];
                end
        end
        SH_RRX:
        begin
                // 33-bit rotate through carry, amount ignored.
                o_result = {i_carry, i_source[31:1]};
                o_carry  = i_source[0];
        end
        default:
        begin
                o_result = i_source;
                o_carry  = i_carry;
        end
        endcase
end

endmodule

`default_nettype wire

// ==== design/shift_pkg.sv ====
`default_nettype none

`include "shift_config.svh"

package shift_pkg;

        // Plain vectors with a meaning of their own.
        typedef logic [`SHIFT_DATA_W-1:0]    word_t;
        typedef logic [`SHIFT_REG_IDX_W-1:0] reg_index_t;
        typedef logic [3:0]                  cond_t;
        typedef logic [4:0]                  alu_op_t;
        typedef logic [`SHIFT_AMT_W-1:0]     shift_amt_t;

        // Shift types understood by the barrel shifter.
        typedef enum logic [2:0]
        {
                SH_LSL = 3'd0,
                SH_LSR = 3'd1,
                SH_ASR = 3'd2,
                SH_ROR = 3'd3,
                SH_RRX = 3'd4
        } shift_type_e;

        // Operand selector from issue.
        // With imm set the payload is the immediate itself.
        // With imm clear the low bits hold a register index.
        typedef struct packed
        {
                logic  imm;
                word_t payload;
        } src_sel_t;

        // Result the ALU is producing in the current cycle.
        typedef struct packed
        {
                logic  valid;
                word_t value;
        } alu_fwd_t;

        // One issued instruction, as presented by the issue stage.
        typedef struct packed
        {
                cond_t       cond;
                reg_index_t  dest_index;
                alu_op_t     alu_op;
                shift_type_e shift_type;
                logic        flag_update;
                logic        disable_shifter;
                src_sel_t    alu_src;
                src_sel_t    shift_src;
                reg_index_t  mem_srcdest_index;
                logic        mem_store;
                logic        irq;
                logic        fiq;
                logic        abt;
                logic        swi;
                logic        und;
                word_t       alu_src_value;
                word_t       shift_src_value;
                word_t       shift_len_value;
                word_t       mem_srcdest_value;
                word_t       pc_plus_8;
        } issue_bundle_t;

        // Registered output of the shift stage, consumed by the ALU.
        typedef struct packed
        {
                cond_t      cond;
                reg_index_t dest_index;
                alu_op_t    alu_op;
                logic       flag_update;
                reg_index_t mem_srcdest_index;
                logic       mem_store;
                logic       irq;
                logic       fiq;
                logic       abt;
                logic       swi;
                logic       und;
                word_t      pc_plus_8;
                word_t      alu_src_value;
                word_t      shifted_value;
                logic       shift_carry;
                word_t      mem_srcdest_value;
        } stage_out_t;

endpackage

`default_nettype wire

// ==== design/shift_config.svh ====
`ifndef SHIFT_CONFIG_SVH
`define SHIFT_CONFIG_SVH

// Width of one data word.
`define SHIFT_DATA_W 32

// Width of a physical register index.
`define SHIFT_REG_IDX_W 6

// Physical index that reads as the program counter.
`define SHIFT_PHY_PC 15

// Condition code that never passes. A cleared slot carries it.
`define SHIFT_COND_NV 15

// Only the low byte of the shift length register counts.
`define SHIFT_AMT_W 8

`endif
